/* Bender.yml */
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/tag_port_if.sv
  - verilog/data_port_if.sv
  - verilog/dcache_tag_store.sv
  - verilog/dcache_data_store.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_properties.sv
      - sim/tb_dcache.sv

/* project.f */
verilog/dcache_pkg.sv
verilog/tag_port_if.sv
verilog/data_port_if.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/dcache_properties.sv
sim/tb_dcache.sv

/* sim/dcache_properties.sv */
`timescale 1ns/1ps

module dcache_properties import dcache_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  arvalid_i,
  input logic  awvalid_i,
  input word_t araddr_i,
  input word_t awaddr_i,
  input logic  mem_ready_i
);

  // one channel at a time, write-back ends before the refill starts
  assert property (@(posedge clk) disable iff (rst) !(arvalid_i && awvalid_i))
    else $error("arvalid_o and awvalid_o high together");

  // address held for the whole burst
  assert property (@(posedge clk) disable iff (rst)
                   arvalid_i && $past(arvalid_i) |-> $stable(araddr_i))
    else $error("araddr_o changed during a read burst");

  assert property (@(posedge clk) disable iff (rst)
                   awvalid_i && $past(awvalid_i) |-> $stable(awaddr_i))
    else $error("awaddr_o changed during a write burst");

  // ready is a single cycle pulse
  assert property (@(posedge clk) disable iff (rst) mem_ready_i |=> !mem_ready_i)
    else $error("mem_ready_o high for more than one cycle");

endmodule

bind dcache_ctrl dcache_properties u_properties (
  .clk         (clk),
  .rst         (rst),
  .arvalid_i   (arvalid_o),
  .awvalid_i   (awvalid_o),
  .araddr_i    (araddr_o),
  .awaddr_i    (awaddr_o),
  .mem_ready_i (mem_ready_o)
);

/* sim/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam int ACCESS_TIMEOUT = 400;  // cycles, write-back plus refill under stalls

  logic       clk;
  logic       rst;
  word_t      mem_addr_i;
  word_t      mem_wdata_i;
  byte_mask_t mem_mask_i;
  logic       mem_write_i;
  logic       mem_valid_i;
  word_t      mem_rdata_o;
  logic       mem_ready_o;
  word_t      araddr_o;
  logic [7:0] arlen_o;
  logic       arvalid_o;
  logic       rvalid_i;
  word_t      rdata_i;
  word_t      awaddr_o;
  logic [7:0] awlen_o;
  logic       awvalid_o;
  word_t      wdata_o;
  byte_mask_t wmask_o;
  logic       wready_i;

  word_t       mem_model [word_t];  // sparse backing memory
  word_t       shadow [word_t];     // what the cpu should see
  logic [31:0] bp_rng   = 32'd68;   // back-pressure
  logic [31:0] stim_rng = 32'd68;   // random mix
  int rcnt, wcnt;                   // beat within the current burst
  int rd_beats = 0, wr_beats = 0, rd_bursts = 0, wr_bursts = 0;
  word_t      last_araddr, last_awaddr;
  logic [7:0] last_arlen, last_awlen;
  int data_errors = 0, check_errors = 0, timeouts = 0, responses = 0;
  word_t exp_word;

  dcache_top uut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // power-up content, every address bit matters
  function automatic word_t init_word(input word_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0000;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input byte_mask_t mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) old_w[8*b +: 8] = new_w[8*b +: 8];
    end
    return old_w;
  endfunction

  function automatic word_t mem_word(input word_t a);
    return mem_model.exists(a) ? mem_model[a] : init_word(a);
  endfunction

  // reference: the cache is transparent, so any address reads as the shadow
  function automatic word_t ref_word(input word_t a);
    return shadow.exists(a) ? shadow[a] : init_word(a);
  endfunction

  task automatic poke_memory(input word_t a, input word_t d);
    mem_model[a] = d;   // behind the cache's back
    shadow[a]    = d;
  endtask

  task automatic expect_equal(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      check_errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("%0d responses, %0d data errors, %0d other errors, %0d timeouts",
             responses, data_errors, check_errors, timeouts);
    if (data_errors + check_errors + timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // called on a falling edge, returns on one
  task automatic cpu_access(input word_t addr, input logic write, input word_t wdata,
                            input byte_mask_t mask, output int latency);
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_mask_i  = mask;
    mem_write_i = write;
    mem_valid_i = 1'b1;
    latency     = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!mem_ready_o && latency < ACCESS_TIMEOUT);
    if (!mem_ready_o) begin
      timeouts++;
      $display("Timeout: no response to the access at %h within %0d cycles", addr, latency);
      finish_run();
    end
    @(negedge clk);  // hold through the ready cycle
    mem_valid_i = 1'b0;
  endtask

  // memory model, decides each beat on the falling edge before it transfers
  always @(negedge clk) begin : memory_model
    word_t beat_addr;
    if (rst) begin
      rvalid_i = 1'b0;
      wready_i = 1'b0;
      rcnt     = 0;
      wcnt     = 0;
    end else begin
      bp_rng   = xorshift32(bp_rng);
      rvalid_i = arvalid_o && (bp_rng[1:0] != 2'b00);  // stall about one in four
      wready_i = awvalid_o && (bp_rng[3:2] != 2'b00);
      if (rvalid_i) begin
        beat_addr = araddr_o + word_t'(4 * rcnt);
        rdata_i   = mem_word(beat_addr);                 // beat n is word n
        rd_beats++;
        if (rcnt == int'(arlen_o)) begin
          rcnt        = 0;
          rd_bursts++;
          last_araddr = araddr_o;
          last_arlen  = arlen_o;
        end else rcnt++;
      end
      if (wready_i) begin
        beat_addr            = awaddr_o + word_t'(4 * wcnt);
        mem_model[beat_addr] = merge_bytes(mem_word(beat_addr), wdata_o, wmask_o);
        wr_beats++;
        if (wcnt == int'(awlen_o)) begin
          wcnt        = 0;
          wr_bursts++;
          last_awaddr = awaddr_o;
          last_awlen  = awlen_o;
        end else wcnt++;
      end
    end
  end

  // compares every response, request is still held here
  always @(negedge clk) begin
    if (!rst && mem_ready_o) begin
      responses++;
      if (mem_write_i) begin
        shadow[mem_addr_i] = merge_bytes(ref_word(mem_addr_i), mem_wdata_i, mem_mask_i);
      end else begin
        exp_word = ref_word(mem_addr_i);
        assert (mem_rdata_o === exp_word) else begin
          data_errors++;
          $display("Error: mem_rdata_o at %h is %h, expected %h", mem_addr_i, mem_rdata_o,
                   exp_word);
        end
      end
    end
  end

  initial begin : stimulus
    word_t addr_a;
    word_t addr_b;
    word_t unc;
    word_t line_word;
    tag_t  rtag;
    int    lat;
    int    n;
    int    bursts_before;
    int    beats_before;
    clk         = 1'b0;
    rst         = 1'b1;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_mask_i  = '0;
    mem_write_i = 1'b0;
    mem_valid_i = 1'b0;
    rvalid_i    = 1'b0;
    rdata_i     = '0;
    wready_i    = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // idle after reset, then a first read refills one line
    expect_equal("mem_ready_o", mem_ready_o, 0);
    expect_equal("arvalid_o", arvalid_o, 0);
    expect_equal("awvalid_o", awvalid_o, 0);
    addr_a        = 32'h0001_2044;
    bursts_before = rd_bursts;
    cpu_access(addr_a, 1'b0, '0, '0, lat);
    expect_equal("arvalid_o burst count", rd_bursts - bursts_before, 1);
    expect_equal("arlen_o", last_arlen, BURST_LEN);
    expect_equal("araddr_o", last_araddr, {addr_a[31:6], 6'b0});

    // masked write hit, then read back, both one cycle
    addr_a = 32'h0003_0254;
    cpu_access(addr_a, 1'b0, '0, '0, lat);
    cpu_access(addr_a, 1'b1, 32'hDEAD_BEEF, 4'b0101, lat);
    expect_equal("mem_ready_o latency", lat, 1);
    cpu_access(addr_a, 1'b0, '0, '0, lat);
    expect_equal("mem_ready_o latency", lat, 1);

    // dirty victim, same index 5 with another tag
    addr_a = 32'h0040_0148;
    addr_b = 32'h0080_0148;
    cpu_access(addr_a, 1'b1, 32'h1234_5678, 4'hF, lat);
    bursts_before = wr_bursts;
    beats_before  = wr_beats;
    cpu_access(addr_b, 1'b0, '0, '0, lat);
    expect_equal("awvalid_o burst count", wr_bursts - bursts_before, 1);
    expect_equal("wready_i beat count", wr_beats - beats_before, WORDS_PER_LINE);
    expect_equal("awaddr_o", last_awaddr, {addr_a[31:6], 6'b0});
    expect_equal("awlen_o", last_awlen, BURST_LEN);
    for (n = 0; n < WORDS_PER_LINE; n++) begin
      line_word = {addr_a[31:6], 6'b0} + word_t'(4 * n);
      expect_equal("memory word", mem_word(line_word), ref_word(line_word));
    end
    cpu_access(addr_a, 1'b0, '0, '0, lat);

    // uncached region, single beats
    unc          = {UNCACHE_TOP, 28'h000_0104};
    beats_before = rd_beats;
    cpu_access(unc, 1'b0, '0, '0, lat);
    expect_equal("arlen_o", last_arlen, 0);
    expect_equal("araddr_o", last_araddr, unc);
    expect_equal("rvalid_i beat count", rd_beats - beats_before, 1);
    poke_memory(unc, 32'hC0DE_0001);
    cpu_access(unc, 1'b0, '0, '0, lat);  // must see the new word
    beats_before = wr_beats;
    cpu_access(unc, 1'b1, 32'h0055_AA00, 4'b0110, lat);
    expect_equal("awlen_o", last_awlen, 0);
    expect_equal("awaddr_o", last_awaddr, unc);
    expect_equal("wready_i beat count", wr_beats - beats_before, 1);
    expect_equal("memory word", mem_word(unc), ref_word(unc));
    cpu_access(unc, 1'b0, '0, '0, lat);

    // random mix over four tags and four indices
    for (n = 0; n < 300; n++) begin
      stim_rng = xorshift32(stim_rng);
      rtag     = tag_t'(stim_rng[4:3]) + 19'd1;
      if (stim_rng[2:0] == 3'd0) addr_a = {UNCACHE_TOP, 22'h0, stim_rng[9:6], 2'b00};
      else addr_a = {rtag, index_t'(stim_rng[6:5]), stim_rng[10:7], 2'b00};
      addr_b   = xorshift32(stim_rng ^ 32'hA5A5_A5A5);  // write data
      cpu_access(addr_a, stim_rng[11], addr_b,
                 (stim_rng[15:12] == 4'h0) ? 4'hF : stim_rng[15:12], lat);
    end

    @(negedge clk);
    finish_run();
  end

endmodule

/* verilog/data_port_if.sv */
`timescale 1ns/1ps

// controller <-> data store
interface data_port_if import dcache_pkg::*; ();

  index_t     index;
  word_sel_t  word_sel;   // word within the line
  word_t      wdata;
  byte_mask_t wmask;      // byte enables for the write
  logic       we;

  word_t      rdata;      // combinational read of index/word_sel

  // one read port, shared by CPU reads and write-back beats
  modport ctrl (output index, word_sel, wdata, wmask, we,
                input  rdata);

  modport store (input  index, word_sel, wdata, wmask, we,
                 output rdata);

  // nothing else on this port, the array lives in the store

endinterface

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // cpu side
  input  word_t      mem_addr_i,
  input  word_t      mem_wdata_i,
  input  byte_mask_t mem_mask_i,
  input  logic       mem_write_i,   // 1 write, 0 read
  input  logic       mem_valid_i,
  output word_t      mem_rdata_o,
  output logic       mem_ready_o,   // one cycle per request

  // memory read channel
  output word_t      araddr_o,
  output logic [7:0] arlen_o,
  output logic       arvalid_o,
  input  logic       rvalid_i,
  input  word_t      rdata_i,

  // memory write channel
  output word_t      awaddr_o,
  output logic [7:0] awlen_o,
  output logic       awvalid_o,
  output word_t      wdata_o,
  output byte_mask_t wmask_o,
  input  logic       wready_i,

  tag_port_if.ctrl   tp,
  data_port_if.ctrl  dp
);

  ctrl_state_t state_q;
  word_sel_t   cnt_q;        // burst beat counter
  word_t       unc_rdata_q;  // uncached read data

  tag_t      req_tag;
  index_t    req_index;
  word_sel_t req_word;
  logic      uncached;

  logic start;        // request sampled in idle
  logic wr_hit;
  logic r_beat;
  logic w_beat;
  logic last_beat;
  logic in_burst;
  logic refill_beat;

  // line aligned burst address
  function automatic word_t line_addr(input tag_t t, input index_t i);
    return {t, i, {OFFSET_W{1'b0}}};
  endfunction

  // address split, request held stable by the cpu
  assign req_tag   = mem_addr_i[OFFSET_W+INDEX_W +: TAG_W];
  assign req_index = mem_addr_i[OFFSET_W +: INDEX_W];
  assign req_word  = mem_addr_i[$clog2(BYTES_PER_WORD) +: WORD_SEL_W];
  assign uncached  = (mem_addr_i[31:28] == UNCACHE_TOP);

  assign start       = (state_q == IDLE) && mem_valid_i;
  assign wr_hit      = start && !uncached && tp.hit && mem_write_i;
  assign r_beat      = arvalid_o && rvalid_i;   // beat moves on this edge
  assign w_beat      = awvalid_o && wready_i;
  assign last_beat   = (cnt_q == word_sel_t'(BURST_LEN));
  assign in_burst    = (state_q == WRITE_BACK) || (state_q == REFILL);
  assign refill_beat = (state_q == REFILL) && r_beat;

  // FSM and valids
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      arvalid_o <= 1'b0;
      awvalid_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (mem_valid_i) begin
            cnt_q <= '0;
            if (uncached) begin
              if (mem_write_i) begin
                state_q   <= UNCACHE_WRITE;
                awvalid_o <= 1'b1;
              end else begin
                state_q   <= UNCACHE_READ;
                arvalid_o <= 1'b1;
              end
            end else if (tp.hit) begin
              state_q <= RESPOND;        // write hit lands on this edge
            end else if (tp.stored_dirty) begin
              state_q   <= WRITE_BACK;   // victim out first
              awvalid_o <= 1'b1;
            end else begin
              state_q   <= REFILL;
              arvalid_o <= 1'b1;
            end
          end
        end
        RESPOND: begin
          state_q <= IDLE;   // valid ignored while ready is up
        end
        WRITE_BACK: begin
          if (w_beat) begin
            if (last_beat) begin
              awvalid_o <= 1'b0;
              arvalid_o <= 1'b1;   // refill follows directly
              cnt_q     <= '0;
              state_q   <= REFILL;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        REFILL: begin
          if (r_beat) begin
            if (last_beat) begin
              arvalid_o <= 1'b0;
              cnt_q     <= '0;
              state_q   <= IDLE;   // held request hits next
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        UNCACHE_READ: begin
          if (r_beat) begin
            arvalid_o <= 1'b0;
            state_q   <= RESPOND;
          end
        end
        UNCACHE_WRITE: begin
          if (w_beat) begin
            awvalid_o <= 1'b0;
            state_q   <= RESPOND;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // burst address and length, only loaded in idle so they stay put
  always_ff @(posedge clk) begin
    if (start && uncached) begin
      araddr_o <= mem_addr_i;   // single word
      awaddr_o <= mem_addr_i;
      arlen_o  <= 8'd0;
      awlen_o  <= 8'd0;
    end else if (start && !tp.hit) begin
      araddr_o <= line_addr(req_tag, req_index);         // new line
      awaddr_o <= line_addr(tp.stored_tag, req_index);   // old line
      arlen_o  <= BURST_LEN;
      awlen_o  <= BURST_LEN;
    end
    if ((state_q == UNCACHE_READ) && r_beat) begin
      unc_rdata_q <= rdata_i;
    end
  end

  // tag store
  assign tp.index    = req_index;
  assign tp.req_tag  = req_tag;
  assign tp.we       = wr_hit || (refill_beat && last_beat);
  assign tp.dirty_wr = (state_q == IDLE);   // write hit sets, refill clears
  assign tp.valid_wr = 1'b1;                // every tag write fills a line

  // data store, counter picks the word during bursts
  assign dp.index    = req_index;
  assign dp.word_sel = in_burst ? cnt_q : req_word;
  assign dp.we       = wr_hit || refill_beat;
  assign dp.wdata    = (state_q == REFILL) ? rdata_i : mem_wdata_i;
  assign dp.wmask    = (state_q == REFILL) ? '1 : mem_mask_i;

  // cpu response
  assign mem_ready_o = (state_q == RESPOND);
  assign mem_rdata_o = uncached ? unc_rdata_q : dp.rdata;

  // write data, beat n of a write-back is word n
  assign wdata_o = (state_q == WRITE_BACK) ? dp.rdata : mem_wdata_i;
  assign wmask_o = (state_q == WRITE_BACK) ? '1 : mem_mask_i;

endmodule

/* verilog/dcache_data_store.sv */
`timescale 1ns/1ps

module dcache_data_store import dcache_pkg::*; (
  input logic        clk,
  data_port_if.store dp
);

  // every word of every line
  word_t mem_q [NUM_LINES * WORDS_PER_LINE];

  // line index on top and word within line below
  logic [INDEX_W+WORD_SEL_W-1:0] waddr;

  assign waddr = {dp.index, dp.word_sel};

  // combinational word read
  // feeds mem_rdata_o on hits and wdata_o on write-back beats
  assign dp.rdata = mem_q[waddr];

  // masked word write where only enabled bytes change
  always_ff @(posedge clk) begin
    if (dp.we) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (dp.wmask[b]) begin
          mem_q[waddr][8*b +: 8] <= dp.wdata[8*b +: 8];  // byte lane b
        end
      end
    end
  end

  // refill writes full words with all mask bits set
  // a write hit uses the cpu byte mask

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

  // address split: tag | index | byte offset
  localparam int TAG_W          = 19;
  localparam int INDEX_W        = 7;
  localparam int OFFSET_W       = 6;   // 64 byte line
  localparam int WORD_SEL_W     = 4;   // word within line
  localparam int BYTES_PER_WORD = 4;

  localparam int NUM_LINES      = 128;
  localparam int WORDS_PER_LINE = 16;

  // burst length minus one, as driven on arlen/awlen
  localparam logic [7:0] BURST_LEN = 8'd15;

  // top nibble of the uncached region
  localparam logic [3:0] UNCACHE_TOP = 4'hA;

  typedef logic [31:0]               word_t;       // data word or address
  typedef logic [TAG_W-1:0]          tag_t;
  typedef logic [INDEX_W-1:0]        index_t;
  typedef logic [WORD_SEL_W-1:0]     word_sel_t;
  typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,           // wait for a request
    RESPOND,        // mem_ready_o high here
    WRITE_BACK,     // dirty victim out
    REFILL,         // line in
    UNCACHE_READ,   // single beat read
    UNCACHE_WRITE   // single beat write
  } ctrl_state_t;

endpackage

/* verilog/dcache_tag_store.sv */
`timescale 1ns/1ps

module dcache_tag_store import dcache_pkg::*; (
  input logic       clk,
  input logic       rst,
  tag_port_if.store tp
);

  // one entry per line, direct mapped
  tag_t                 tag_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;

  tag_t cur_tag;    // tag at the addressed line
  logic cur_valid;
  logic cur_dirty;

  // zero cycle lookup
  assign cur_tag   = tag_mem[tp.index];
  assign cur_valid = valid_q[tp.index];
  assign cur_dirty = dirty_q[tp.index];

  // hit only on a valid line with matching tag
  assign tp.hit = cur_valid && (cur_tag == tp.req_tag);

  // victim info for the write-back decision
  assign tp.stored_tag   = cur_tag;
  assign tp.stored_dirty = cur_valid & cur_dirty;  // invalid line is never dirty

  // tag array, plain storage
  always_ff @(posedge clk) begin
    if (tp.we) begin
      tag_mem[tp.index] <= tp.req_tag;
    end
  end

  // state bits, cleared on reset so the cache starts empty
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tp.we) begin
      valid_q[tp.index] <= tp.valid_wr;
      dirty_q[tp.index] <= tp.dirty_wr;  // set on write hit, cleared on refill
    end
  end

  // write hit and refill end both come through the same strobe
  // so the line state never splits across two edges

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // cpu load/store port
  input  word_t      mem_addr_i,
  input  word_t      mem_wdata_i,
  input  byte_mask_t mem_mask_i,
  input  logic       mem_write_i,
  input  logic       mem_valid_i,
  output word_t      mem_rdata_o,
  output logic       mem_ready_o,

  // memory read channel
  output word_t      araddr_o,
  output logic [7:0] arlen_o,
  output logic       arvalid_o,
  input  logic       rvalid_i,
  input  word_t      rdata_i,

  // memory write channel
  output word_t      awaddr_o,
  output logic [7:0] awlen_o,
  output logic       awvalid_o,
  output word_t      wdata_o,
  output byte_mask_t wmask_o,
  input  logic       wready_i
);

  tag_port_if  tag_port ();
  data_port_if data_port ();

  // tag, valid, dirty
  dcache_tag_store u_tag_store (
    .clk (clk),
    .rst (rst),
    .tp  (tag_port.store)
  );

  // line words, same index as the tags
  dcache_data_store u_data_store (
    .clk (clk),
    .dp  (data_port.store)
  );

  // FSM, combines both lookups
  dcache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_mask_i  (mem_mask_i),
    .mem_write_i (mem_write_i),
    .mem_valid_i (mem_valid_i),
    .mem_rdata_o (mem_rdata_o),
    .mem_ready_o (mem_ready_o),
    .araddr_o    (araddr_o),
    .arlen_o     (arlen_o),
    .arvalid_o   (arvalid_o),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .awaddr_o    (awaddr_o),
    .awlen_o     (awlen_o),
    .awvalid_o   (awvalid_o),
    .wdata_o     (wdata_o),
    .wmask_o     (wmask_o),
    .wready_i    (wready_i),
    .tp          (tag_port.ctrl),
    .dp          (data_port.ctrl)
  );

endmodule

/* verilog/tag_port_if.sv */
`timescale 1ns/1ps

// controller <-> tag store
interface tag_port_if import dcache_pkg::*; ();

  index_t index;         // line being looked up or written
  tag_t   req_tag;       // compare tag, also the tag to write
  logic   we;            // write strobe, takes effect at the edge
  logic   dirty_wr;
  logic   valid_wr;

  logic   hit;           // valid and tag match
  tag_t   stored_tag;    // victim tag
  logic   stored_dirty;  // victim needs write-back

  modport ctrl (output index, req_tag, we, dirty_wr, valid_wr,
                input  hit, stored_tag, stored_dirty);

  modport store (input  index, req_tag, we, dirty_wr, valid_wr,
                 output hit, stored_tag, stored_dirty);

endinterface
